//--- ldcore_top.f
verilog/ldcore_pkg.sv
verilog/ldcore_sequencer.sv
verilog/ldcore_step_decoder.sv
verilog/ldcore_regfile.sv
verilog/ldcore_addr_unit.sv
verilog/ldcore_wb_master.sv
verilog/ldcore_top.sv
dv/ldcore_properties.sv
dv/ldcore_tb.sv

//--- Makefile
# Verilator flow for the LD core testbench.
TOP := ldcore_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f ldcore_top.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/ldcore_tb.sv
// ######################################
// Testbench of the LD core. Programs start at 0000, and each test resets
// the core and ends at halt. Ack delays are 0 to 3 cycles when enabled.
// ######################################
`timescale 1ns/10ps
`default_nettype none

module ldcore_tb;
    import ldcore_pkg::*;

    logic              clk;
    logic              rst_n;
    logic [DATA_W-1:0] wb_dat_r;
    logic              wb_ack;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    logic [DATA_W-1:0] wb_dat_w;
    logic              halted;
    logic              illegal;

    logic [DATA_W-1:0] mem     [65536];
    logic [DATA_W-1:0] ref_mem [65536];
    logic [ADDR_W-1:0] exp_adr [$];
    logic [DATA_W-1:0] exp_dat [$];
    logic [ADDR_W-1:0] nn_val  [4];  // Operand addresses shared by the repeated tests.
    logic [15:0]       data_val [4];
    logic [ADDR_W-1:0] prog_pc;
    logic [15:0]       lfsr_q;
    logic              rand_waits;
    logic              timed_out;
    string             test_name;
    int                errors;
    int                tests;
    int                failed;

    ldcore_top i_ldcore_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .halted   (halted),
        .illegal  (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR x^16+x^14+x^13+x^11+1 stepped once per bit taken.
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            v = (v << 1) | int'(lfsr_q[0]);
        end
        return v;
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("ERROR %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    // ######################################
    // Reference model of the instruction set
    // ######################################
    function automatic int ref_run(output logic exp_illegal);
        logic [15:0] pc;
        logic [15:0] regs [4];
        logic [15:0] nn;
        logic [7:0]  op;
        logic [1:0]  dd;
        logic        done;
        int          acc;
        int          count;
        for (int a = 0; a < 65536; a++) begin
            ref_mem[a] = mem[a];
        end
        for (int r = 0; r < 4; r++) begin
            regs[r] = '0;
        end
        exp_adr.delete();
        exp_dat.delete();
        pc          = '0;
        done        = 1'b0;
        exp_illegal = 1'b0;
        acc         = 0;
        count       = 0;
        while (!done && count < 1000) begin
            op    = ref_mem[pc];
            pc    = pc + 16'd1;
            acc   = acc + 1;
            count = count + 1;
            case (op)
                8'h76: done = 1'b1;
                8'h01, 8'h11, 8'h21, 8'h31: begin
                    regs[op[5:4]] = {ref_mem[pc + 16'd1], ref_mem[pc]};
                    pc  = pc + 16'd2;
                    acc = acc + 2;
                end
                8'hED: begin
                    op = ref_mem[pc];
                    dd = op[5:4];
                    nn = {ref_mem[pc + 16'd2], ref_mem[pc + 16'd1]};
                    pc = pc + 16'd3;
                    case (op)
                        8'h4B, 8'h5B, 8'h6B, 8'h7B: begin
                            regs[dd] = {ref_mem[nn + 16'd1], ref_mem[nn]};
                            acc = acc + 5;
                        end
                        8'h43, 8'h53, 8'h63, 8'h73: begin
                            exp_adr.push_back(nn);
                            exp_dat.push_back(regs[dd][7:0]);
                            exp_adr.push_back(nn + 16'd1);
                            exp_dat.push_back(regs[dd][15:8]);
                            ref_mem[nn]         = regs[dd][7:0];
                            ref_mem[nn + 16'd1] = regs[dd][15:8];
                            acc = acc + 5;
                        end
                        default: begin
                            acc         = acc + 1;  // Only the byte after ED is read.
                            exp_illegal = 1'b1;
                            done        = 1'b1;
                        end
                    endcase
                end
                default: begin
                    if (op != 8'h00) begin  // NOP does nothing.
                        exp_illegal = 1'b1;
                        done        = 1'b1;
                    end
                end
            endcase
        end
        return acc;
    endfunction

    // Memory model. Reads and writes happen at the ack.
    initial begin : memory_model
        int   waits;
        logic busy;
        waits    = 0;
        busy     = 1'b0;
        wb_ack   = 1'b0;
        wb_dat_r = '0;
        forever begin
            @(posedge clk);
            #1;
            if (wb_ack) begin
                wb_ack = 1'b0;
            end else if (wb_stb) begin
                if (!busy) begin
                    busy  = 1'b1;
                    waits = rand_waits ? take_bits(2) : 0;
                end
                if (waits == 0) begin
                    busy   = 1'b0;
                    wb_ack = 1'b1;
                    if (wb_we) begin
                        mem[wb_adr] = wb_dat_w;
                    end else begin
                        wb_dat_r = mem[wb_adr];
                    end
                end else begin
                    waits--;
                end
            end
        end
    end

    // Compares each acknowledged write in the middle of its ack cycle.
    initial begin : write_monitor
        forever begin
            @(negedge clk);
            if (rst_n && wb_cyc && wb_stb && wb_we && wb_ack) begin
                if (exp_adr.size() == 0) begin
                    $display("Unexpected write in %s to address %h", test_name, wb_adr);
                    errors++;
                end else begin
                    check_value("write address", int'(exp_adr.pop_front()), int'(wb_adr));
                    check_value("write data", int'(exp_dat.pop_front()), int'(wb_dat_w));
                end
            end
        end
    end

    // ######################################
    // Program builders
    // ######################################
    task automatic clear_memory();
        for (int a = 0; a < 65536; a++) begin
            mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'hA5;
        end
        prog_pc = '0;
    endtask

    task automatic emit(input logic [7:0] b);
        mem[prog_pc] = b;
        prog_pc      = prog_pc + 16'd1;
    endtask

    task automatic imm_store_program();
        clear_memory();
        for (int d = 0; d < 4; d++) begin
            emit({2'b00, 2'(d), 4'h1});
            emit(nn_val[d][7:0]);
            emit(nn_val[d][15:8]);
            emit(8'hED);
            emit({2'b01, 2'(d), 4'h3});  // Store back at nn itself.
            emit(nn_val[d][7:0]);
            emit(nn_val[d][15:8]);
        end
        emit(8'h76);
    endtask

    task automatic indirect_program();
        logic [15:0] dst;
        clear_memory();
        for (int d = 0; d < 4; d++) begin
            dst = nn_val[d] + 16'h8000;
            mem[nn_val[d]]         = data_val[d][7:0];
            mem[nn_val[d] + 16'd1] = data_val[d][15:8];
            emit(8'hED);
            emit({2'b01, 2'(d), 4'hB});
            emit(nn_val[d][7:0]);
            emit(nn_val[d][15:8]);
            emit(8'hED);
            emit({2'b01, 2'(d), 4'h3});
            emit(dst[7:0]);
            emit(dst[15:8]);
        end
        emit(8'h76);
    endtask

    task automatic wrap_program();
        clear_memory();
        mem[16'hFFFF] = data_val[0][7:0];
        emit(8'hED);  // HL high comes from 0000 after the wrap.
        emit(8'h6B);
        emit(8'hFF);
        emit(8'hFF);
        emit(8'hED);
        emit(8'h63);
        emit(8'h00);
        emit(8'h50);
        emit(8'h11);
        emit(8'h34);
        emit(8'h12);
        emit(8'hED);
        emit(8'h53);
        emit(8'hFF);
        emit(8'hFF);
        emit(8'h76);
    endtask

    task automatic nop_halt_program();
        clear_memory();
        repeat (5) emit(8'h00);
        emit(8'h76);
    endtask

    task automatic illegal_program(input logic [7:0] op_a, input logic [7:0] op_b);
        clear_memory();
        emit(8'h21);
        emit(data_val[1][7:0]);
        emit(data_val[1][15:8]);
        emit(8'hED);
        emit(8'h63);
        emit(8'h00);
        emit(8'h60);
        emit(op_a);
        emit(op_b);
        emit(8'hED);  // Never reached.
        emit(8'h63);
        emit(8'h00);
        emit(8'h61);
        emit(8'h76);
    endtask

    task automatic run_test(input string name);
        int   acc;
        int   limit;
        int   cycles;
        int   err_before;
        logic exp_illegal;
        logic bus_after_halt;
        if (timed_out) begin
            return;
        end
        test_name      = name;
        err_before     = errors;
        bus_after_halt = 1'b0;
        acc            = ref_run(exp_illegal);
        limit          = acc * 6 + 20;  // Three wait, ack, done and restart cycles at most.
        rst_n          = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n  = 1'b1;
        cycles = 0;
        while (!halted && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: %s did not halt within %0d cycles", name, limit);
            timed_out = 1'b1;
            errors++;
        end else begin
            repeat (8) begin
                @(posedge clk);
                #1;
                bus_after_halt = bus_after_halt | wb_cyc;
            end
            if (bus_after_halt) begin
                $display("Bus cycle started after halt in %s", name);
                errors++;
            end
            check_value("illegal flag", int'(exp_illegal), int'(illegal));
            check_value("missing writes", 0, exp_adr.size());
        end
        tests++;
        if (errors != err_before) begin
            failed++;
        end
        $display("%s %s", (errors == err_before) ? "ok  " : "FAIL", name);
    endtask

    initial begin : main
        rst_n      = 1'b0;
        rand_waits = 1'b0;
        timed_out  = 1'b0;
        lfsr_q     = 16'd28382;
        errors     = 0;
        tests      = 0;
        failed     = 0;
        for (int d = 0; d < 4; d++) begin
            nn_val[d]   = {2'b01, 14'(take_bits(14))};
            data_val[d] = 16'(take_bits(16));
        end
        imm_store_program();
        run_test("ld_imm_store");
        indirect_program();
        run_test("ld_ind");
        wrap_program();
        run_test("addr_wrap");
        nop_halt_program();
        run_test("nop_halt");
        illegal_program(8'hED, 8'h00);
        run_test("illegal_ed_00");
        illegal_program(8'h3E, 8'h12);
        run_test("illegal_3e");
        rand_waits = 1'b1;
        imm_store_program();
        run_test("ld_imm_store_waits");
        indirect_program();
        run_test("ld_ind_waits");
        $display("Tests run %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/ldcore_properties.sv
// ######################################
// Wishbone classic master checks, bound to every ldcore_wb_master.
// ######################################
`timescale 1ns/10ps
`default_nettype none

module ldcore_properties (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              wb_cyc,
    input  wire                              wb_stb,
    input  wire                              wb_we,
    input  wire                              wb_ack,
    input  wire  [ldcore_pkg::ADDR_W-1:0]    wb_adr,
    input  wire  [ldcore_pkg::DATA_W-1:0]    wb_dat_w
);

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_cyc)
        else $error("stb high without cyc");

    // Request fields hold while the slave stalls.
    req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w))
        else $error("request changed before ack");

    cyc_drops: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc && wb_ack |=> !wb_cyc)
        else $error("cyc still high after ack");

    idle_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc && wb_ack |=> !wb_stb ##1 !wb_stb)
        else $error("new stb right after ack");

endmodule

bind ldcore_wb_master ldcore_properties i_properties (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_ack   (wb_ack),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w)
);

`default_nettype wire

//--- verilog/ldcore_top.sv
// ######################################
// LD core top level. Results leave only through bus writes.
// ######################################
`timescale 1ns/10ps
`default_nettype none

module ldcore_top (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire  [ldcore_pkg::DATA_W-1:0]    wb_dat_r,
    input  wire                              wb_ack,
    output logic                             wb_cyc,
    output logic                             wb_stb,
    output logic                             wb_we,
    output logic [ldcore_pkg::ADDR_W-1:0]    wb_adr,
    output logic [ldcore_pkg::DATA_W-1:0]    wb_dat_w,
    output logic                             halted,
    output logic                             illegal
);
    import ldcore_pkg::*;

    logic               bus_req;
    logic               bus_we;
    logic               bus_done;
    logic [DATA_W-1:0]  rd_data;
    logic [DATA_W-1:0]  rd_byte;
    logic [ADDR_W-1:0]  adr;
    logic               fetch;
    table_idx_e         table_idx;
    logic [PAIR_W-1:0]  dd;
    logic [STEP_W-1:0]  step;
    logic [ASEL_W-1:0]  addr_sel;
    logic               pc_inc;
    logic               opop_lo_load;
    logic               opop_hi_load;
    logic               reg_lo_write;
    logic               reg_hi_write;
    logic               reg_lo_read;
    logic               reg_hi_read;
    logic               last_step;

    ldcore_sequencer i_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_done  (bus_done),
        .rd_data   (rd_data),
        .last_step (last_step),
        .bus_req   (bus_req),
        .fetch     (fetch),
        .table_idx (table_idx),
        .dd        (dd),
        .step      (step),
        .halted    (halted),
        .illegal   (illegal)
    );

    ldcore_step_decoder i_step_decoder (
        .table_idx    (table_idx),
        .dd           (dd),
        .step         (step),
        .addr_sel     (addr_sel),
        .pc_inc       (pc_inc),
        .opop_lo_load (opop_lo_load),
        .opop_hi_load (opop_hi_load),
        .reg_lo_write (reg_lo_write),
        .reg_hi_write (reg_hi_write),
        .reg_lo_read  (reg_lo_read),
        .reg_hi_read  (reg_hi_read),
        .bus_we       (bus_we),
        .last_step    (last_step)
    );

    ldcore_regfile i_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .dd      (dd),
        .wr_lo   (reg_lo_write),
        .wr_hi   (reg_hi_write),
        .rd_lo   (reg_lo_read),
        .rd_hi   (reg_hi_read),
        .wr_data (rd_data),
        .act     (bus_done),
        .rd_byte (rd_byte)
    );

    ldcore_addr_unit i_addr_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch        (fetch),
        .addr_sel     (addr_sel),
        .pc_inc       (pc_inc),
        .opop_lo_load (opop_lo_load),
        .opop_hi_load (opop_hi_load),
        .load_data    (rd_data),
        .act          (bus_done),
        .adr          (adr)
    );

    ldcore_wb_master i_wb_master (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus_req  (bus_req),
        .bus_we   (bus_we),
        .adr_in   (adr),
        .dat_in   (rd_byte),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .bus_done (bus_done),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

//--- verilog/ldcore_wb_master.sv
// ######################################
// Wishbone classic master, one byte per request, no bursts.
// ######################################
`timescale 1ns/10ps
`default_nettype none

module ldcore_wb_master (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              bus_req,
    input  wire                              bus_we,
    input  wire  [ldcore_pkg::ADDR_W-1:0]    adr_in,
    input  wire  [ldcore_pkg::DATA_W-1:0]    dat_in,
    input  wire  [ldcore_pkg::DATA_W-1:0]    wb_dat_r,
    input  wire                              wb_ack,
    output logic                             wb_cyc,
    output logic                             wb_stb,
    output logic                             wb_we,
    output logic [ldcore_pkg::ADDR_W-1:0]    wb_adr,
    output logic [ldcore_pkg::DATA_W-1:0]    wb_dat_w,
    output logic                             bus_done,
    output logic [ldcore_pkg::DATA_W-1:0]    rd_data
);
    logic start;

    // Never start in the cycle after ack.
    assign start = bus_req && !wb_cyc && !bus_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            wb_we    <= 1'b0;
            bus_done <= 1'b0;
        end else begin
            bus_done <= wb_cyc && wb_ack;
            if (wb_cyc && wb_ack) begin
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
                wb_we  <= 1'b0;
            end else if (start) begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
                wb_we  <= bus_we;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr   <= adr_in;
            wb_dat_w <= dat_in;
        end
        if (wb_cyc && wb_ack) begin
            rd_data <= wb_dat_r;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ldcore_addr_unit.sv
// ######################################
// PC and operand latch. OPOP+1 wraps at 16 bits.
// ######################################
`timescale 1ns/10ps
`default_nettype none

module ldcore_addr_unit (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              fetch,
    input  wire  [ldcore_pkg::ASEL_W-1:0]    addr_sel,
    input  wire                              pc_inc,
    input  wire                              opop_lo_load,
    input  wire                              opop_hi_load,
    input  wire  [ldcore_pkg::DATA_W-1:0]    load_data,
    input  wire                              act,
    output logic [ldcore_pkg::ADDR_W-1:0]    adr
);
    import ldcore_pkg::*;

    logic [ADDR_W-1:0] pc_q;
    logic [ADDR_W-1:0] opop_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (act && (fetch || pc_inc)) begin
            pc_q <= pc_q + ADDR_W'(1);  // Every PC-sourced byte moves PC on.
        end
    end

    always_ff @(posedge clk) begin
        if (act && opop_lo_load) begin
            opop_q[DATA_W-1:0] <= load_data;
        end
        if (act && opop_hi_load) begin
            opop_q[ADDR_W-1:DATA_W] <= load_data;
        end
    end

    always_comb begin
        if (fetch) begin
            adr = pc_q;
        end else begin
            case (addr_sel)
                ASEL_OPOP:  adr = opop_q;
                ASEL_OPOP1: adr = opop_q + ADDR_W'(1);
                default:    adr = pc_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/ldcore_regfile.sv
// ######################################
// Register pairs BC, DE, HL, SP. One byte written per act.
// ######################################
`timescale 1ns/10ps
`default_nettype none

module ldcore_regfile (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire  [ldcore_pkg::PAIR_W-1:0]    dd,
    input  wire                              wr_lo,
    input  wire                              wr_hi,
    input  wire                              rd_lo,
    input  wire                              rd_hi,
    input  wire  [ldcore_pkg::DATA_W-1:0]    wr_data,
    input  wire                              act,
    output logic [ldcore_pkg::DATA_W-1:0]    rd_byte
);
    import ldcore_pkg::*;

    logic [2*DATA_W-1:0] pair_q [4];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                pair_q[i] <= '0;
            end
        end else if (act) begin
            if (wr_lo) begin
                pair_q[dd][DATA_W-1:0] <= wr_data;  // C, E, L or SP low.
            end
            if (wr_hi) begin
                pair_q[dd][2*DATA_W-1:DATA_W] <= wr_data;
            end
        end
    end

    // Store data byte. Zero when no read strobe is set.
    always_comb begin
        if (rd_hi) begin
            rd_byte = pair_q[dd][2*DATA_W-1:DATA_W];
        end else if (rd_lo) begin
            rd_byte = pair_q[dd][DATA_W-1:0];
        end else begin
            rd_byte = '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ldcore_step_decoder.sv
// ######################################
// Combinational step decoder. Strobes take effect only at bus_done.
// ######################################
`timescale 1ns/10ps
`default_nettype none

module ldcore_step_decoder (
    input  ldcore_pkg::table_idx_e           table_idx,
    input  wire  [ldcore_pkg::PAIR_W-1:0]    dd,
    input  wire  [ldcore_pkg::STEP_W-1:0]    step,
    output logic [ldcore_pkg::ASEL_W-1:0]    addr_sel,
    output logic                             pc_inc,
    output logic                             opop_lo_load,
    output logic                             opop_hi_load,
    output logic                             reg_lo_write,
    output logic                             reg_hi_write,
    output logic                             reg_lo_read,
    output logic                             reg_hi_read,
    output logic                             bus_we,
    output logic                             last_step
);
    import ldcore_pkg::*;

    // ######################################
    // Instruction timing table
    // ######################################
    always_comb begin
        addr_sel     = ASEL_PC;
        pc_inc       = 1'b0;
        opop_lo_load = 1'b0;
        opop_hi_load = 1'b0;
        reg_lo_write = 1'b0;
        reg_hi_write = 1'b0;
        reg_lo_read  = 1'b0;
        reg_hi_read  = 1'b0;
        bus_we       = 1'b0;
        last_step    = 1'b0;
        case (table_idx)
            T_LD_DD_NN: begin
                pc_inc = 1'b1;  // Both immediate bytes come from PC.
                if (step == STEP_W'(0)) begin
                    reg_lo_write = 1'b1;
                end else begin
                    reg_hi_write = 1'b1;
                    last_step    = 1'b1;
                end
            end
            T_LD_DD_IND, T_ST_IND_DD: begin
                case (step)
                    STEP_W'(0): begin
                        pc_inc       = 1'b1;
                        opop_lo_load = 1'b1;
                    end
                    STEP_W'(1): begin
                        pc_inc       = 1'b1;
                        opop_hi_load = 1'b1;
                    end
                    STEP_W'(2): begin
                        addr_sel     = ASEL_OPOP;
                        reg_lo_write = (table_idx == T_LD_DD_IND);
                        reg_lo_read  = (table_idx == T_ST_IND_DD);
                        bus_we       = (table_idx == T_ST_IND_DD);
                    end
                    default: begin
                        addr_sel     = ASEL_OPOP1;
                        reg_hi_write = (table_idx == T_LD_DD_IND);
                        reg_hi_read  = (table_idx == T_ST_IND_DD);
                        bus_we       = (table_idx == T_ST_IND_DD);
                        last_step    = 1'b1;
                    end
                endcase
            end
            default: last_step = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/ldcore_sequencer.sv
// ######################################
// Control FSM. One bus request is outstanding at a time and the step
// advances only on bus_done, so late acks just stretch an instruction.
// ######################################
`timescale 1ns/10ps
`default_nettype none

module ldcore_sequencer (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              bus_done,
    input  wire  [ldcore_pkg::DATA_W-1:0]    rd_data,
    input  wire                              last_step,
    output logic                             bus_req,
    output logic                             fetch,
    output ldcore_pkg::table_idx_e           table_idx,
    output logic [ldcore_pkg::PAIR_W-1:0]    dd,
    output logic [ldcore_pkg::STEP_W-1:0]    step,
    output logic                             halted,
    output logic                             illegal
);
    import ldcore_pkg::*;

    seq_state_e  state_q;
    logic        wait_q;   // A request is in flight.
    table_idx_e  idx_dec;

    // Maps an opcode byte to its table index. Prefixed bytes follow ED.
    function automatic table_idx_e decode_op(input logic [DATA_W-1:0] op,
                                             input logic prefixed);
        table_idx_e idx;
        idx = T_ILLEGAL;
        if (prefixed) begin
            if (op[7:6] == 2'b01 && op[3:0] == 4'hB) begin
                idx = T_LD_DD_IND;
            end else if (op[7:6] == 2'b01 && op[3:0] == 4'h3) begin
                idx = T_ST_IND_DD;
            end
        end else if (op == 8'h00) begin
            idx = T_NOP;
        end else if (op == 8'h76) begin
            idx = T_HALT;
        end else if (op[7:6] == 2'b00 && op[3:0] == 4'h1) begin
            idx = T_LD_DD_NN;
        end
        return idx;
    endfunction

    assign idx_dec = decode_op(rd_data, state_q == PREFIX);

    assign bus_req = (state_q != HALTED) && !wait_q;
    assign fetch   = (state_q == FETCH) || (state_q == PREFIX);
    assign halted  = (state_q == HALTED);

    // ######################################
    // State, step and table index
    // ######################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= FETCH;
            wait_q    <= 1'b0;
            table_idx <= T_NOP;
            dd        <= '0;
            step      <= '0;
            illegal   <= 1'b0;
        end else begin
            if (bus_req) begin
                wait_q <= 1'b1;
            end else if (bus_done) begin
                wait_q <= 1'b0;
            end
            if (bus_done) begin
                case (state_q)
                    FETCH, PREFIX: begin
                        if (state_q == FETCH && rd_data == PREFIX_ED) begin
                            state_q <= PREFIX;
                        end else begin
                            table_idx <= idx_dec;
                            dd        <= rd_data[5:4];  // Pair field of both opcode forms.
                            step      <= '0;
                            case (idx_dec)
                                T_NOP:                state_q <= FETCH;
                                T_HALT:               state_q <= HALTED;
                                T_ILLEGAL: begin
                                    state_q <= HALTED;
                                    illegal <= 1'b1;
                                end
                                default:              state_q <= EXEC;
                            endcase
                        end
                    end
                    EXEC: begin
                        if (last_step) begin
                            state_q   <= FETCH;
                            table_idx <= T_NOP;  // Keeps decoder strobes quiet in fetch.
                            step      <= '0;
                        end else begin
                            step <= step + STEP_W'(1);
                        end
                    end
                    default: state_q <= state_q;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/ldcore_pkg.sv
// ######################################
// Shared types and widths of the LD core. Opcode bytes outside the
// supported subset decode to T_ILLEGAL.
// ######################################
`default_nettype none

package ldcore_pkg;

    // ######################################
    // Widths
    // ######################################
    localparam int STEP_W = 3;  // Enough for the four execute steps.
    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;
    localparam int PAIR_W = 2;  // BC=0, DE=1, HL=2, SP=3.

    localparam logic [DATA_W-1:0] PREFIX_ED = 8'hED;

    // Address source selection driven by the step decoder.
    localparam int               ASEL_W     = 2;
    localparam logic [ASEL_W-1:0] ASEL_PC    = 2'd0;
    localparam logic [ASEL_W-1:0] ASEL_OPOP  = 2'd1;
    localparam logic [ASEL_W-1:0] ASEL_OPOP1 = 2'd2;

    // ######################################
    // Enums
    // ######################################
    typedef enum logic [1:0] {
        FETCH  = 2'd0,
        PREFIX = 2'd1,
        EXEC   = 2'd2,
        HALTED = 2'd3
    } seq_state_e;

    typedef enum logic [2:0] {
        T_NOP       = 3'd0,
        T_LD_DD_NN  = 3'd1,  // 01/11/21/31
        T_LD_DD_IND = 3'd2,  // ED 4B/5B/6B/7B
        T_ST_IND_DD = 3'd3,  // ED 43/53/63/73
        T_HALT      = 3'd4,
        T_ILLEGAL   = 3'd5
    } table_idx_e;

endpackage

`default_nettype wire
